// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - include_dirs:
      - .
    files:
      - i2c_pkg.sv
      - i2c_cmd_if.sv
      - i2c_baudgen.sv
      - i2c_wb_regs.sv
      - i2c_byte_engine.sv
      - i2c_master.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_i2c_slave_model.sv
      - i2c_master_assertions.sv
      - tb_i2c_master.sv

// ==== files.f ====
+incdir+.
i2c_pkg.sv
i2c_cmd_if.sv
i2c_baudgen.sv
i2c_wb_regs.sv
i2c_byte_engine.sv
i2c_master.sv
tb_i2c_slave_model.sv
i2c_master_assertions.sv
tb_i2c_master.sv

// ==== i2c_baudgen.sv ====
`timescale 1ns/1ns
`include "i2c_settings.svh"

module i2c_baudgen (
  input  logic clk_i,
  input  logic rst_i,
  input  logic enable_i,
  output logic tick_o
);

  localparam int DIV = `I2C_TICK_DIV;
  localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;
  localparam logic [CW-1:0] LAST = CW'(DIV - 1);

  logic [CW-1:0] cnt_q;

  // restarts from zero on every enable so the first phase is full length
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (!enable_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (cnt_q == LAST) begin
      cnt_q  <= '0;
      tick_o <= 1'b1; // terminal count
    end else begin
      cnt_q  <= cnt_q + 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

// ==== i2c_byte_engine.sv ====
`timescale 1ns/1ns

module i2c_byte_engine (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      scl_i,
  input  logic      sda_i,
  output logic      scl_o,
  output logic      sda_o,
  i2c_cmd_if.engine cmd
);

  i2c_pkg::i2c_state_e state_q;
  logic [7:0]          shift_q;
  logic [7:0]          rx_q;
  logic [2:0]          bcnt_q;
  logic                nak_q;
  logic                busy;
  logic                tick;
  logic                hi_tick;

  assign busy    = (state_q != i2c_pkg::ST_IDLE);
  assign hi_tick = tick && scl_i; // high phases freeze while SCL is stretched

  assign cmd.done      = (state_q == i2c_pkg::ST_DONE);
  assign cmd.rx_byte   = rx_q;
  assign cmd.nak_err   = nak_q;
  assign cmd.sda_level = sda_o;

  i2c_baudgen i_baudgen (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .enable_i (busy),
    .tick_o   (tick)
  );

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= i2c_pkg::ST_IDLE;
      scl_o   <= 1'b1;
      sda_o   <= 1'b1;
      shift_q <= 8'h00;
      rx_q    <= 8'h00;
      bcnt_q  <= 3'd0;
      nak_q   <= 1'b0;
    end else begin
      case (state_q)
        i2c_pkg::ST_IDLE: begin
          if (cmd.cmd_valid) begin
            bcnt_q <= 3'd7;
            case (cmd.cmd)
              i2c_pkg::CMD_START: begin
                nak_q   <= 1'b0;
                sda_o   <= 1'b1; // release SDA before SCL
                state_q <= i2c_pkg::ST_START1;
              end
              i2c_pkg::CMD_STOP: state_q <= i2c_pkg::ST_STOP1;
              i2c_pkg::CMD_READ: begin
                sda_o   <= 1'b1; // slave drives the data
                state_q <= i2c_pkg::ST_READ1;
              end
              default: begin
                shift_q <= cmd.tx_byte;
                state_q <= i2c_pkg::ST_WRITE1;
              end
            endcase
          end
        end
        // start or repeated start
        i2c_pkg::ST_START1: if (tick) begin
          scl_o   <= 1'b1;
          state_q <= i2c_pkg::ST_START2;
        end
        i2c_pkg::ST_START2: if (hi_tick) begin
          sda_o   <= 1'b0; // start condition
          state_q <= i2c_pkg::ST_START3;
        end
        i2c_pkg::ST_START3: if (hi_tick) state_q <= i2c_pkg::ST_START4;
        i2c_pkg::ST_START4: if (hi_tick) begin
          scl_o   <= 1'b0;
          shift_q <= cmd.addr_byte; // address byte follows the start
          bcnt_q  <= 3'd7;
          state_q <= i2c_pkg::ST_WRITE1;
        end
        i2c_pkg::ST_WRITE1: if (tick) begin
          sda_o   <= shift_q[7];
          state_q <= i2c_pkg::ST_WRITE2;
        end
        i2c_pkg::ST_WRITE2: if (tick) begin
          scl_o   <= 1'b1;
          state_q <= i2c_pkg::ST_WRITE3;
        end
        i2c_pkg::ST_WRITE3: if (hi_tick) state_q <= i2c_pkg::ST_WRITE4;
        i2c_pkg::ST_WRITE4: if (hi_tick) begin
          scl_o   <= 1'b0;
          shift_q <= {shift_q[6:0], 1'b0};
          bcnt_q  <= bcnt_q - 1'b1;
          state_q <= (bcnt_q == 3'd0) ? i2c_pkg::ST_SACK1 : i2c_pkg::ST_WRITE1;
        end
        i2c_pkg::ST_SACK1: if (tick) begin
          sda_o   <= 1'b1;
          state_q <= i2c_pkg::ST_SACK2;
        end
        i2c_pkg::ST_SACK2: if (tick) begin
          scl_o   <= 1'b1;
          state_q <= i2c_pkg::ST_SACK3;
        end
        i2c_pkg::ST_SACK3: if (hi_tick) state_q <= i2c_pkg::ST_SACK4;
        i2c_pkg::ST_SACK4: if (hi_tick) begin
          scl_o   <= 1'b0;
          state_q <= sda_i ? i2c_pkg::ST_NAK : i2c_pkg::ST_DONE; // sample ack at end of high
        end
        i2c_pkg::ST_NAK: begin
          nak_q   <= 1'b1;
          state_q <= i2c_pkg::ST_DONE;
        end
        i2c_pkg::ST_READ1: if (tick) state_q <= i2c_pkg::ST_READ2;
        i2c_pkg::ST_READ2: if (tick) begin
          scl_o   <= 1'b1;
          state_q <= i2c_pkg::ST_READ3;
        end
        i2c_pkg::ST_READ3: if (hi_tick) begin
          rx_q    <= {rx_q[6:0], sda_i}; // msb first
          state_q <= i2c_pkg::ST_READ4;
        end
        i2c_pkg::ST_READ4: if (hi_tick) begin
          scl_o   <= 1'b0;
          bcnt_q  <= bcnt_q - 1'b1;
          state_q <= (bcnt_q == 3'd0) ? i2c_pkg::ST_MACK1 : i2c_pkg::ST_READ1;
        end
        i2c_pkg::ST_MACK1: if (tick) begin
          sda_o   <= cmd.mack;
          state_q <= i2c_pkg::ST_MACK2;
        end
        i2c_pkg::ST_MACK2: if (tick) begin
          scl_o   <= 1'b1;
          state_q <= i2c_pkg::ST_MACK3;
        end
        i2c_pkg::ST_MACK3: if (hi_tick) state_q <= i2c_pkg::ST_MACK4;
        i2c_pkg::ST_MACK4: if (hi_tick) begin
          scl_o   <= 1'b0;
          state_q <= i2c_pkg::ST_DONE;
        end
        i2c_pkg::ST_STOP1: if (tick) begin
          sda_o   <= 1'b0; // SCL still low here
          state_q <= i2c_pkg::ST_STOP2;
        end
        i2c_pkg::ST_STOP2: if (tick) begin
          scl_o   <= 1'b1;
          state_q <= i2c_pkg::ST_STOP3;
        end
        i2c_pkg::ST_STOP3: if (hi_tick) begin
          sda_o   <= 1'b1; // stop condition
          state_q <= i2c_pkg::ST_STOP4;
        end
        i2c_pkg::ST_STOP4: if (hi_tick) state_q <= i2c_pkg::ST_DONE;
        default: state_q <= i2c_pkg::ST_IDLE; // done lasts one cycle
      endcase
    end
  end

endmodule

// ==== i2c_cmd_if.sv ====
`timescale 1ns/1ns

interface i2c_cmd_if;

  logic              cmd_valid; // one-cycle launch pulse
  i2c_pkg::i2c_cmd_e cmd;
  logic [7:0]        addr_byte;
  logic [7:0]        tx_byte;
  logic              mack;      // SDA level in master-ack phase

  logic              done;      // one pulse per command
  logic [7:0]        rx_byte;
  logic              nak_err;   // sticky until next start
  logic              sda_level;

  modport ctrl (
    output cmd_valid, cmd, addr_byte, tx_byte, mack,
    input  done, rx_byte, nak_err, sda_level
  );

  modport engine (
    input  cmd_valid, cmd, addr_byte, tx_byte, mack,
    output done, rx_byte, nak_err, sda_level
  );

endinterface

// ==== i2c_master.sv ====
`timescale 1ns/1ns

module i2c_master (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [1:0]  adr_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        scl_o,
  output logic        sda_o,
  input  logic        scl_i,
  input  logic        sda_i
);

  i2c_cmd_if i_cmd_if ();

  i2c_wb_regs i_wb_regs (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .we_i  (we_i),
    .adr_i (adr_i),
    .sel_i (sel_i),
    .dat_i (dat_i),
    .dat_o (dat_o),
    .ack_o (ack_o),
    .scl_i (scl_i),
    .sda_i (sda_i),
    .cmd   (i_cmd_if.ctrl)
  );

  i2c_byte_engine i_byte_engine (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .scl_i (scl_i),
    .sda_i (sda_i),
    .scl_o (scl_o),
    .sda_o (sda_o),
    .cmd   (i_cmd_if.engine)
  );

endmodule

// ==== i2c_master_assertions.sv ====
`timescale 1ns/1ns

module i2c_master_assertions (
  input logic                clk_i,
  input logic                rst_i,
  input logic                cyc_i,
  input logic                stb_i,
  input logic                ack_o,
  input logic                scl_o,
  input logic                sda_o,
  input i2c_pkg::i2c_state_e state_i
);

  int fail_cnt = 0;

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |=> !ack_o)
    else begin
      $error("ack_o held for more than one cycle");
      fail_cnt++;
    end

  ack_needs_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |-> (cyc_i && stb_i))
    else begin
      $error("ack_o high without cyc_i and stb_i");
      fail_cnt++;
    end

  // only start and stop conditions may move SDA under a high SCL
  sda_stable_scl_high: assert property (@(posedge clk_i) disable iff (rst_i)
    (scl_o && $past(scl_o) && (sda_o != $past(sda_o))) |->
      (state_i inside {i2c_pkg::ST_START3, i2c_pkg::ST_STOP4}))
    else begin
      $error("sda_o changed while scl_o high outside start or stop");
      fail_cnt++;
    end

endmodule

bind i2c_master i2c_master_assertions i_master_assertions (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .cyc_i   (cyc_i),
  .stb_i   (stb_i),
  .ack_o   (ack_o),
  .scl_o   (scl_o),
  .sda_o   (sda_o),
  .state_i (i_byte_engine.state_q)
);

// ==== i2c_pkg.sv ====
package i2c_pkg;

  // same encoding as control register bits 1:0
  typedef enum logic [1:0] {
    CMD_START = 2'd0,
    CMD_STOP  = 2'd1,
    CMD_READ  = 2'd2,
    CMD_WRITE = 2'd3
  } i2c_cmd_e;

  // phases 1/2 are SCL low, 3/4 are SCL high (start/stop excepted)
  typedef enum logic [4:0] {
    ST_IDLE,
    ST_START1, ST_START2, ST_START3, ST_START4,
    ST_STOP1,  ST_STOP2,  ST_STOP3,  ST_STOP4,
    ST_WRITE1, ST_WRITE2, ST_WRITE3, ST_WRITE4,
    ST_READ1,  ST_READ2,  ST_READ3,  ST_READ4,
    ST_SACK1,  ST_SACK2,  ST_SACK3,  ST_SACK4,
    ST_MACK1,  ST_MACK2,  ST_MACK3,  ST_MACK4,
    ST_NAK,
    ST_DONE
  } i2c_state_e;

endpackage

// ==== i2c_settings.svh ====
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// system clock, matches the 40 ns period
`define I2C_CLK_FREQ 25000000

// four ticks per SCL bit
`define I2C_QUARTER_RATE 2500000

// clocks per quarter-bit tick
`define I2C_TICK_DIV (`I2C_CLK_FREQ / `I2C_QUARTER_RATE)

`endif

// ==== i2c_wb_regs.sv ====
`timescale 1ns/1ns

module i2c_wb_regs (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [1:0]  adr_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  input  logic        scl_i,
  input  logic        sda_i,
  i2c_cmd_if.ctrl     cmd
);

  typedef enum logic {
    WB_IDLE,
    WB_WAIT
  } wb_state_e;

  wb_state_e         state_q;
  logic              req_q;       // register access, ack next cycle
  logic              cmd_valid_q;
  i2c_pkg::i2c_cmd_e cmd_q;
  logic              mack_q;
  logic [7:0]        addr_q;
  logic [7:0]        data_q;
  logic              access;
  logic              launch;
  logic [31:0]       status;

  // strobes are ignored while a cycle is still in flight
  assign access = cyc_i && stb_i && (state_q == WB_IDLE) && !req_q && !ack_o;
  assign launch = access && we_i && (adr_i == 2'd1) && sel_i[0];

  assign status = {27'h0, mack_q, scl_i, sda_i, cmd.sda_level, cmd.nak_err};

  assign cmd.cmd_valid = cmd_valid_q;
  assign cmd.cmd       = cmd_q;
  assign cmd.addr_byte = addr_q;
  assign cmd.tx_byte   = data_q;
  assign cmd.mack      = mack_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= WB_IDLE;
      req_q       <= 1'b0;
      ack_o       <= 1'b0;
      cmd_valid_q <= 1'b0;
      cmd_q       <= i2c_pkg::CMD_START;
      mack_q      <= 1'b0;
      addr_q      <= 8'h00;
      data_q      <= 8'h00;
    end else begin
      cmd_valid_q <= launch;
      req_q       <= access && !launch;
      ack_o       <= req_q || ((state_q == WB_WAIT) && cmd.done);

      if (launch) begin
        state_q <= WB_WAIT; // hold ack until the engine finishes
        cmd_q   <= i2c_pkg::i2c_cmd_e'(dat_i[1:0]);
      end else if ((state_q == WB_WAIT) && cmd.done) begin
        state_q <= WB_IDLE;
      end

      if (access && we_i && (adr_i == 2'd0)) begin
        if (sel_i[2]) begin
          mack_q <= dat_i[16];
        end
        if (sel_i[1]) begin
          addr_q <= dat_i[15:8];
        end
        if (sel_i[0]) begin
          data_q <= dat_i[7:0];
        end
      end
    end
  end

  // read data is valid together with ack_o
  always_ff @(posedge clk_i) begin
    if (access && !we_i) begin
      if (adr_i == 2'd1) begin
        dat_o <= status;
      end else if (adr_i == 2'd0) begin
        dat_o <= {16'h0, addr_q, cmd.rx_byte};
      end else begin
        dat_o <= 32'h0;
      end
    end
  end

endmodule

// ==== tb_i2c_master.sv ====
`timescale 1ns/1ns
`include "i2c_settings.svh"

module tb_i2c_master;

  localparam int TIMEOUT_CYCLES = 20 * 40 * `I2C_TICK_DIV; // twenty stretched bytes

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        cyc_i;
  logic        stb_i;
  logic        we_i;
  logic [1:0]  adr_i;
  logic [3:0]  sel_i;
  logic [31:0] dat_i;
  logic [31:0] dat_o;
  logic        ack_o;
  logic        scl_o;
  logic        sda_o;
  wire         scl_i;
  wire         sda_i;
  logic        stretch;
  logic [7:0]  tx_byte;
  logic [7:0]  model_rx;
  logic        model_mack;
  logic        model_stop;
  int          cycles = 0;
  int          seed = 32'ha16b3c0f;
  int          lat;
  int          lat_plain;
  int          lat_stretch;

  always #20 clk_i = ~clk_i;

  i2c_master i_i2c_master (
    .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_i), .stb_i (stb_i),
    .we_i  (we_i),  .adr_i (adr_i), .sel_i (sel_i), .dat_i (dat_i),
    .dat_o (dat_o), .ack_o (ack_o), .scl_o (scl_o), .sda_o (sda_o),
    .scl_i (scl_i), .sda_i (sda_i)
  );

  tb_i2c_slave_model #(.ADDR(7'h50)) i_slave (
    .clk_i (clk_i), .rst_i (rst_i), .m_scl_i (scl_o), .m_sda_i (sda_o),
    .stretch_i (stretch), .tx_byte_i (tx_byte), .bus_scl_o (scl_i),
    .bus_sda_o (sda_i), .rx_byte_o (model_rx), .mack_o (model_mack),
    .stop_seen_o (model_stop)
  );

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      report_failure("timeout waiting for the DUT to finish");
    end
  end

  always @(i_i2c_master.i_master_assertions.fail_cnt) begin
    if (i_i2c_master.i_master_assertions.fail_cnt != 0) begin
      report_failure("a bound assertion on the DUT failed");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
      report_failure("value check failed");
    end
  endtask

  // one Wishbone cycle, returns read data and ack latency
  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [3:0] sel,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output int latency);
    cyc_i   = 1'b1;
    stb_i   = 1'b1;
    we_i    = we;
    adr_i   = adr;
    sel_i   = sel;
    dat_i   = wdata;
    latency = 0;
    do begin
      @(posedge clk_i);
      #1;
      latency++;
    end while (!ack_o);
    rdata = dat_o;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic reg_write(input logic [1:0] adr, input logic [3:0] sel, input logic [31:0] d);
    logic [31:0] rd;
    int          l;
    wb_access(1'b1, adr, sel, d, rd, l);
    check_value("write ack latency", l, 2);
  endtask

  task automatic reg_read(input logic [1:0] adr, input logic [31:0] mask,
                          input logic [31:0] exp, input string name);
    logic [31:0] rd;
    int          l;
    wb_access(1'b0, adr, 4'hf, 32'h0, rd, l);
    check_value("read ack latency", l, 2);
    check_value(name, rd & mask, exp);
  endtask

  task automatic issue_cmd(input i2c_pkg::i2c_cmd_e c, output int latency);
    logic [31:0] rd;
    wb_access(1'b1, 2'd1, 4'b0001, {30'h0, c}, rd, latency);
  endtask

  initial begin
    rst_i   = 1'b1;
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    we_i    = 1'b0;
    adr_i   = 2'd0;
    sel_i   = 4'h0;
    dat_i   = 32'h0;
    stretch = 1'b0;
    tx_byte = 8'h00;
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(posedge clk_i);
    #1;

    reg_write(2'd0, 4'b0111, 32'h0000_a05c);
    reg_read(2'd0, 32'hffff_ff00, 32'h0000_a000, "addr reg");
    reg_write(2'd0, 4'b0001, 32'h0001_ff33); // only the data byte
    reg_read(2'd0, 32'hffff_ff00, 32'h0000_a000, "addr kept by byte select");
    reg_read(2'd1, 32'h0000_0010, 32'h0, "mack kept");

    issue_cmd(i2c_pkg::CMD_START, lat);
    check_value("slave addr byte", model_rx, 8'ha0);
    reg_read(2'd1, 32'h1f, 32'h06, "status after start");

    reg_write(2'd0, 4'b0001, 32'h0000_003c);
    issue_cmd(i2c_pkg::CMD_WRITE, lat);
    check_value("slave data byte", model_rx, 8'h3c);
    reg_read(2'd1, 32'h1, 32'h0, "nak after write");

    tx_byte = $random(seed);
    reg_write(2'd0, 4'b0110, 32'h0000_a100); // read address, mack 0
    issue_cmd(i2c_pkg::CMD_START, lat);
    check_value("slave read addr", model_rx, 8'ha1);
    issue_cmd(i2c_pkg::CMD_READ, lat);
    reg_read(2'd0, 32'hff, {24'h0, tx_byte}, "rx byte mack 0");
    check_value("mack 0 seen", model_mack, 1'b0);
    tx_byte = $random(seed);
    reg_write(2'd0, 4'b0100, 32'h0001_0000);
    issue_cmd(i2c_pkg::CMD_READ, lat_plain);
    reg_read(2'd0, 32'hff, {24'h0, tx_byte}, "rx byte mack 1");
    check_value("mack 1 seen", model_mack, 1'b1);

    issue_cmd(i2c_pkg::CMD_STOP, lat);
    check_value("scl_o after stop", scl_o, 1'b1);
    check_value("sda_o after stop", sda_o, 1'b1);
    check_value("stop condition", model_stop, 1'b1);
    reg_read(2'd1, 32'h1f, 32'h1e, "status after stop");

    reg_write(2'd0, 4'b0010, 32'h0000_4200); // nobody answers 7'h21
    issue_cmd(i2c_pkg::CMD_START, lat);
    reg_read(2'd1, 32'h1f, 32'h17, "status after nak");
    reg_write(2'd0, 4'b0010, 32'h0000_a000);
    issue_cmd(i2c_pkg::CMD_START, lat);
    reg_read(2'd1, 32'h1, 32'h0, "nak cleared by start");

    reg_write(2'd0, 4'b0010, 32'h0000_a100);
    issue_cmd(i2c_pkg::CMD_START, lat);
    tx_byte = $random(seed);
    stretch = 1'b1;
    issue_cmd(i2c_pkg::CMD_READ, lat_stretch);
    stretch = 1'b0;
    reg_read(2'd0, 32'hff, {24'h0, tx_byte}, "stretched rx byte");
    assert (lat_stretch > lat_plain) else begin
      report_failure("stretched read finished no later than a plain read");
    end
    issue_cmd(i2c_pkg::CMD_STOP, lat);

    if (i_i2c_master.i_master_assertions.fail_cnt != 0) begin
      report_failure("a bound assertion on the DUT failed");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== tb_i2c_slave_model.sv ====
`timescale 1ns/1ns

module tb_i2c_slave_model #(
  parameter logic [6:0] ADDR = 7'h50
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       m_scl_i,     // master SCL output
  input  logic       m_sda_i,     // master SDA output
  input  logic       stretch_i,
  input  logic [7:0] tx_byte_i,
  output logic       bus_scl_o,
  output logic       bus_sda_o,
  output logic [7:0] rx_byte_o,
  output logic       mack_o,
  output logic       stop_seen_o
);

  logic       scl_d;
  logic       sda_d;
  logic       scl_drv;
  logic       ack_drv;
  logic       tx_phase;   // slave transmits bytes
  logic       tx_drive;   // data bit on SDA right now
  logic       active;
  logic       first;
  logic       selected;
  logic       rw;
  logic [3:0] bit_cnt;
  logic [7:0] shreg;
  logic [2:0] rd_idx;
  int         stretch_left;

  // open-drain wired-AND
  assign bus_scl_o = m_scl_i & scl_drv;
  assign bus_sda_o = m_sda_i & ack_drv & (tx_drive ? tx_byte_i[rd_idx] : 1'b1);

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      scl_d        <= 1'b1;
      sda_d        <= 1'b1;
      scl_drv      <= 1'b1;
      ack_drv      <= 1'b1;
      tx_phase     <= 1'b0;
      tx_drive     <= 1'b0;
      active       <= 1'b0;
      first        <= 1'b0;
      selected     <= 1'b0;
      rw           <= 1'b0;
      bit_cnt      <= 4'd0;
      shreg        <= 8'h00;
      rd_idx       <= 3'd7;
      stretch_left <= 0;
      rx_byte_o    <= 8'h00;
      mack_o       <= 1'b0;
      stop_seen_o  <= 1'b0;
    end else begin
      scl_d <= bus_scl_o;
      sda_d <= bus_sda_o;
      if (stretch_left > 0) begin
        stretch_left <= stretch_left - 1;
        if (stretch_left == 1) begin
          scl_drv <= 1'b1;
        end
      end
      if (bus_scl_o && scl_d && sda_d && !bus_sda_o) begin // start
        active      <= 1'b1;
        first       <= 1'b1;
        selected    <= 1'b0;
        rw          <= 1'b0;
        bit_cnt     <= 4'd0;
        tx_phase    <= 1'b0;
        tx_drive    <= 1'b0;
        ack_drv     <= 1'b1;
        stop_seen_o <= 1'b0;
      end else if (bus_scl_o && scl_d && !sda_d && bus_sda_o) begin // stop
        active      <= 1'b0;
        tx_phase    <= 1'b0;
        tx_drive    <= 1'b0;
        ack_drv     <= 1'b1;
        stop_seen_o <= 1'b1;
      end else if (active && bus_scl_o && !scl_d) begin // rising SCL
        if (bit_cnt < 4'd8) begin
          shreg   <= {shreg[6:0], bus_sda_o};
          bit_cnt <= bit_cnt + 4'd1;
        end else if (bit_cnt == 4'd8) begin
          if (tx_phase) begin
            mack_o <= bus_sda_o;
          end
          bit_cnt <= 4'd9;
        end
      end else if (active && !bus_scl_o && scl_d) begin // falling SCL
        if (bit_cnt == 4'd8) begin
          if (tx_phase) begin
            tx_drive <= 1'b0; // release for master ack
          end else begin
            if (first) begin
              selected <= (shreg[7:1] == ADDR);
              rw       <= shreg[0];
            end
            if (first || selected) begin
              rx_byte_o <= shreg;
            end
            ack_drv <= !(first ? (shreg[7:1] == ADDR) : selected);
          end
        end else if (bit_cnt == 4'd9) begin
          bit_cnt <= 4'd0;
          first   <= 1'b0;
          ack_drv <= 1'b1;
          if (selected && rw && (first || !mack_o)) begin
            tx_phase <= 1'b1;
            tx_drive <= 1'b1;
            rd_idx   <= 3'd7;
          end else begin
            tx_phase <= 1'b0;
            tx_drive <= 1'b0;
          end
        end else if (tx_phase) begin
          rd_idx <= 3'(7 - bit_cnt);
          if (stretch_i && (bit_cnt == 4'd4)) begin
            scl_drv      <= 1'b0;
            stretch_left <= 70; // about 50 past the normal low phase
          end
        end
      end
    end
  end

endmodule
